/* ram_pkg.sv */
// Shared types, sizes and helper function for the credit FIFO and its RAM.
// Files refer to these by scoped names only.
package ram_pkg;

    // ------------------------------------------------------------------------
    // RAM configuration
    // ------------------------------------------------------------------------

    // Read latency against clock rate
    typedef enum logic {
        OPT_MODE_LATENCY,
        OPT_MODE_TIMING
    } opt_mode_t;

    // Extra read-data stages behind the registered read
    function automatic int get_uram_rd_pipeline_stages(
        input int        addr_wid,
        input opt_mode_t mode
    );
        if (mode == OPT_MODE_LATENCY) begin
            return 0;
        end
        // Deeper arrays cascade more blocks and need a second stage
        if (addr_wid <= 12) begin
            return 1;
        end
        return 2;
    endfunction

    // ------------------------------------------------------------------------
    // FIFO sizing
    // ------------------------------------------------------------------------

    localparam int FIFO_ADDR_WID = 6;
    localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_WID;
    localparam opt_mode_t FIFO_OPT_MODE = OPT_MODE_TIMING;
    localparam int FIFO_RD_LATENCY =
        1 + get_uram_rd_pipeline_stages(FIFO_ADDR_WID, FIFO_OPT_MODE);

    // Receiver credits held after reset
    localparam int RX_CREDITS = 4;
    localparam int RX_CREDIT_WID = $clog2(RX_CREDITS + 1);

    // ------------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } fifo_entry_t;

    localparam int FIFO_ENTRY_WID = $bits(fifo_entry_t);

endpackage : ram_pkg

/* ram_sdp_uram.sv */
// Simple dual-port RAM with registered read and optional read-data stages.
// One write port and one read port on a single clock.
module ram_sdp_uram #(
    parameter int                ADDR_WID = 8,
    parameter int                DATA_WID = 32,
    parameter ram_pkg::opt_mode_t OPT_MODE = ram_pkg::OPT_MODE_TIMING
) (
    input  logic                clk,
    // Fast clear of the array for simulation init
    input  logic                wr_srst,

    // Write port
    input  logic                wr_en,
    input  logic                wr_req,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [DATA_WID-1:0] wr_data,

    // Read port
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data
);

    localparam int DEPTH = 2 ** ADDR_WID;
    localparam int RD_PIPELINE_STAGES =
        ram_pkg::get_uram_rd_pipeline_stages(ADDR_WID, OPT_MODE);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // Intended for UltraRAM mapping
    logic [DATA_WID-1:0] mem [DEPTH];
    logic [DATA_WID-1:0] rd_data_q;

    always_ff @(posedge clk) begin
        if (wr_srst) begin
            mem <= '{default: '0};
        end else if (wr_en && wr_req) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read gives the first cycle of latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_q <= mem[rd_addr];
        end
    end

    // ------------------------------------------------------------------------
    // Read-data pipeline
    // ------------------------------------------------------------------------

    generate
        if (RD_PIPELINE_STAGES > 0) begin : g_rd_pipe
            logic [RD_PIPELINE_STAGES-1:0] en_p;
            logic [DATA_WID-1:0]           data_p [RD_PIPELINE_STAGES];

            // Enable follows its data so reads can overlap
            always_ff @(posedge clk) begin
                if (wr_srst) begin
                    en_p <= '0;
                end else begin
                    en_p[0] <= rd_en;
                    for (int i = 1; i < RD_PIPELINE_STAGES; i++) begin
                        en_p[i] <= en_p[i-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (en_p[0]) begin
                    data_p[0] <= rd_data_q;
                end
                for (int i = 1; i < RD_PIPELINE_STAGES; i++) begin
                    if (en_p[i]) begin
                        data_p[i] <= data_p[i-1];
                    end
                end
            end

            assign rd_data = data_p[RD_PIPELINE_STAGES-1];
        end else begin : g_rd_direct
            assign rd_data = rd_data_q;
        end
    endgenerate

endmodule : ram_sdp_uram

/* credit_fifo_wr.sv */
// Write side of the credit FIFO that takes upstream entries into the RAM.
// Space is guaranteed by the upstream credit loop, so there is no full check.
module credit_fifo_wr (
    input  logic                                clk,
    input  logic                                wr_srst,

    // Upstream
    input  logic                                in_valid,
    input  ram_pkg::fifo_entry_t                in_entry,

    // RAM write port
    output logic                                wr_en,
    output logic                                wr_req,
    output logic [ram_pkg::FIFO_ADDR_WID-1:0]   wr_addr,
    output logic [ram_pkg::FIFO_ENTRY_WID-1:0]  wr_data,

    // To read control, with wrap bit
    output logic [ram_pkg::FIFO_ADDR_WID:0]     wr_ptr
);

    // ------------------------------------------------------------------------
    // Write pointer
    // ------------------------------------------------------------------------

    // Wraps through twice the depth; top bit tells full from empty
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            wr_ptr <= '0;
        end else if (in_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // RAM write port
    // ------------------------------------------------------------------------

    // Port always enabled and each accepted entry is one request
    assign wr_en   = 1'b1;
    assign wr_req  = in_valid;
    assign wr_addr = wr_ptr[ram_pkg::FIFO_ADDR_WID-1:0];
    assign wr_data = in_entry;

endmodule : credit_fifo_wr

/* credit_fifo_rd.sv */
// Read side of the credit FIFO that issues RAM reads against receiver credits,
// tracks reads in flight and hands freed slots back upstream.
module credit_fifo_rd (
    input  logic                                clk,
    input  logic                                wr_srst,

    // From write control
    input  logic [ram_pkg::FIFO_ADDR_WID:0]     wr_ptr,

    // Receiver credit return
    input  logic                                credit_in,

    // RAM read port
    output logic                                rd_en,
    output logic [ram_pkg::FIFO_ADDR_WID-1:0]   rd_addr,
    input  logic [ram_pkg::FIFO_ENTRY_WID-1:0]  rd_data,

    // Downstream
    output logic                                out_valid,
    output ram_pkg::fifo_entry_t                out_entry,

    // Upstream credit return
    output logic                                credit_out
);

    logic [ram_pkg::FIFO_ADDR_WID:0]      rd_ptr;
    logic                                 empty;
    logic [ram_pkg::RX_CREDIT_WID-1:0]    rx_cnt;
    logic [ram_pkg::FIFO_RD_LATENCY-1:0]  rd_vld;

    // ------------------------------------------------------------------------
    // Read issue
    // ------------------------------------------------------------------------

    // Same pointer including wrap bit means nothing stored
    assign empty = (wr_ptr == rd_ptr);

    // A read needs data and a receiver slot
    assign rd_en   = !empty && (rx_cnt != '0);
    assign rd_addr = rd_ptr[ram_pkg::FIFO_ADDR_WID-1:0];

    always_ff @(posedge clk) begin
        if (wr_srst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Receiver credit counter
    // ------------------------------------------------------------------------

    // Spend on issue and refill on credit_in; both at once cancel out
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            rx_cnt <= ram_pkg::RX_CREDIT_WID'(ram_pkg::RX_CREDITS);
        end else begin
            case ({rd_en, credit_in})
                2'b10:   rx_cnt <= rx_cnt - 1'b1;
                2'b01:   rx_cnt <= rx_cnt + 1'b1;
                default: rx_cnt <= rx_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Reads in flight
    // ------------------------------------------------------------------------

    // One bit per RAM latency cycle with the last bit lined up with rd_data
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            rd_vld <= '0;
        end else begin
            rd_vld[0] <= rd_en;
            for (int i = 1; i < ram_pkg::FIFO_RD_LATENCY; i++) begin
                rd_vld[i] <= rd_vld[i-1];
            end
        end
    end

    assign out_valid = rd_vld[ram_pkg::FIFO_RD_LATENCY-1];
    assign out_entry = ram_pkg::fifo_entry_t'(rd_data);

    // ------------------------------------------------------------------------
    // Upstream credit return
    // ------------------------------------------------------------------------

    // Slot is free once its read is issued
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            credit_out <= 1'b0;
        end else begin
            credit_out <= rd_en;
        end
    end

endmodule : credit_fifo_rd

/* credit_fifo.sv */
// Top level of the credit FIFO with write control, dual-port RAM and read control.
// Upstream and downstream both use credit flow control and have no ready signals.
module credit_fifo (
    input  logic                  clk,
    input  logic                  wr_srst,

    // Upstream
    input  logic                  in_valid,
    input  ram_pkg::fifo_entry_t  in_entry,
    output logic                  credit_out,

    // Downstream
    output logic                  out_valid,
    output ram_pkg::fifo_entry_t  out_entry,
    input  logic                  credit_in
);

    // ------------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------------

    logic                                wr_en;
    logic                                wr_req;
    logic [ram_pkg::FIFO_ADDR_WID-1:0]   wr_addr;
    logic [ram_pkg::FIFO_ENTRY_WID-1:0]  wr_data;
    logic [ram_pkg::FIFO_ADDR_WID:0]     wr_ptr;

    logic                                rd_en;
    logic [ram_pkg::FIFO_ADDR_WID-1:0]   rd_addr;
    logic [ram_pkg::FIFO_ENTRY_WID-1:0]  rd_data;

    credit_fifo_wr credit_fifo_wr_inst (
        .clk      (clk),
        .wr_srst  (wr_srst),
        .in_valid (in_valid),
        .in_entry (in_entry),
        .wr_en    (wr_en),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_ptr   (wr_ptr)
    );

    ram_sdp_uram #(
        .ADDR_WID (ram_pkg::FIFO_ADDR_WID),
        .DATA_WID (ram_pkg::FIFO_ENTRY_WID),
        .OPT_MODE (ram_pkg::FIFO_OPT_MODE)
    ) ram_sdp_uram_inst (
        .clk      (clk),
        .wr_srst  (wr_srst),
        .wr_en    (wr_en),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    credit_fifo_rd credit_fifo_rd_inst (
        .clk        (clk),
        .wr_srst    (wr_srst),
        .wr_ptr     (wr_ptr),
        .credit_in  (credit_in),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .credit_out (credit_out)
    );

endmodule : credit_fifo

/* credit_fifo_tb.sv */
// Self-checking testbench for the credit FIFO with model sender and receiver,
// an in-order scoreboard and assertions on latency, credits and data.
module credit_fifo_tb;

    localparam int MAX_CYCLES = 20000;

    logic                 clk = 1'b0;
    logic                 wr_srst;
    logic                 in_valid = 1'b0;
    ram_pkg::fifo_entry_t in_entry = '0;
    logic                 credit_out;
    logic                 out_valid;
    ram_pkg::fifo_entry_t out_entry;
    logic                 credit_in = 1'b0;

    // Model state
    ram_pkg::fifo_entry_t sb[$];
    ram_pkg::fifo_entry_t exp_entry;
    ram_pkg::fifo_entry_t new_entry;
    int  cyc = 0;
    bit  models_on = 1'b0;
    bit  in_valid_seen = 1'b0;
    int  snd_credits = ram_pkg::FIFO_DEPTH;
    int  send_left = 0;
    bit  send_dense = 1'b0;
    bit  rx_active = 1'b1;
    int  rx_owed = 0;
    int  phase_sent = 0;
    int  stall_outputs = 0;
    int  last_send_cyc = -1;
    int  first_credit_cyc = -1;
    int  first_out_cyc = -1;
    int  zero_run = 0;

    credit_fifo credit_fifo_inst (
        .clk        (clk),
        .wr_srst    (wr_srst),
        .in_valid   (in_valid),
        .in_entry   (in_entry),
        .credit_out (credit_out),
        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .credit_in  (credit_in)
    );

    task automatic stop_with_failure(input bit mismatch, input string msg);
        if (mismatch) begin
            $display("Mismatch at time %0t: %s", $time, msg);
        end else begin
            $display("Error at time %0t: %s", $time, msg);
        end
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    initial begin
        forever #4 clk = ~clk;
    end

    // Cycle count and watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            stop_with_failure(1'b0, "timeout, run did not complete in time");
        end
    end

    // ------------------------------------------------------------------------
    // Concurrent checks
    // ------------------------------------------------------------------------

    // Outputs idle right out of reset
    assert property (@(posedge clk) wr_srst |=> (!out_valid && !credit_out))
        else stop_with_failure(1'b1, "output active after reset");

    // Delivered entry had its slot freed upstream one cycle after issue
    assert property (@(posedge clk) disable iff (wr_srst)
        out_valid |-> $past(credit_out, 1))
        else stop_with_failure(1'b1, "out_valid without earlier credit_out");

    // ------------------------------------------------------------------------
    // Monitor, scoreboard and model sender and receiver
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        #1;
        if (models_on) begin
            if (!in_valid_seen) begin
                assert (!out_valid && !credit_out)
                    else stop_with_failure(1'b1, "output before any write");
            end

            if (credit_out) begin
                assert (snd_credits < ram_pkg::FIFO_DEPTH)
                    else stop_with_failure(1'b1, "credit_out while sender holds all credits");
                snd_credits++;
                if (first_credit_cyc < 0) begin
                    first_credit_cyc = cyc;
                end
            end

            if (out_valid) begin
                assert (sb.size() != 0)
                    else stop_with_failure(1'b0, "out_valid with no entry outstanding");
                exp_entry = sb.pop_front();
                assert (out_entry.data == exp_entry.data)
                    else stop_with_failure(1'b1, $sformatf("data got %h expected %h",
                                                           out_entry.data, exp_entry.data));
                assert (out_entry.last == exp_entry.last)
                    else stop_with_failure(1'b1, $sformatf("last got %0b expected %0b",
                                                           out_entry.last, exp_entry.last));
                rx_owed++;
                if (!rx_active) begin
                    stall_outputs++;
                end
                assert (rx_owed <= ram_pkg::RX_CREDITS)
                    else stop_with_failure(1'b1, "receiver credit limit exceeded");
                if (first_out_cyc < 0) begin
                    first_out_cyc = cyc;
                end
            end

            // Sender spends one credit per entry
            in_valid = 1'b0;
            if (send_left > 0 && snd_credits > 0 && (send_dense || $urandom_range(1, 0) == 1)) begin
                new_entry.data = $urandom;
                new_entry.last = 1'($urandom_range(1, 0));
                in_entry = new_entry;
                in_valid = 1'b1;
                sb.push_back(new_entry);
                snd_credits--;
                send_left--;
                phase_sent++;
                last_send_cyc = cyc;
                in_valid_seen = 1'b1;
            end

            // Receiver hands credits back after a random delay
            credit_in = 1'b0;
            if (rx_active && rx_owed > 0 && $urandom_range(3, 0) == 0) begin
                credit_in = 1'b1;
                rx_owed--;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test phases
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(87575));
        wr_srst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        wr_srst = 1'b0;
        @(negedge clk);
        models_on = 1'b1;
        repeat (4) @(negedge clk);

        // Single entry into an empty FIFO
        send_dense = 1'b1;
        send_left = 1;
        while (first_out_cyc < 0) @(negedge clk);
        assert (first_credit_cyc - last_send_cyc == 2)
            else stop_with_failure(1'b1, "credit_out latency wrong");
        assert (first_out_cyc - last_send_cyc == 3)
            else stop_with_failure(1'b1, "out_valid latency wrong");

        // Random traffic with random receiver credit returns
        send_dense = 1'b0;
        send_left = 500;
        while (send_left != 0 || sb.size() != 0 || rx_owed != 0 ||
               snd_credits != ram_pkg::FIFO_DEPTH) @(negedge clk);
        repeat (2) @(negedge clk);

        // Receiver stalled while the sender fills until it runs dry
        rx_active = 1'b0;
        phase_sent = 0;
        stall_outputs = 0;
        send_dense = 1'b1;
        send_left = ram_pkg::FIFO_DEPTH + ram_pkg::RX_CREDITS + 8;
        zero_run = 0;
        while (zero_run < 8) begin
            @(negedge clk);
            if (snd_credits == 0) begin
                zero_run++;
            end else begin
                zero_run = 0;
            end
        end
        send_left = 0;
        assert (phase_sent == ram_pkg::FIFO_DEPTH + ram_pkg::RX_CREDITS)
            else stop_with_failure(1'b1, $sformatf("sent %0d entries before stall", phase_sent));
        assert (stall_outputs == ram_pkg::RX_CREDITS)
            else stop_with_failure(1'b1, $sformatf("%0d outputs during stall", stall_outputs));

        // Resume and drain
        rx_active = 1'b1;
        while (sb.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk);
        assert (snd_credits == ram_pkg::FIFO_DEPTH)
            else stop_with_failure(1'b1, "sender credits not restored");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : credit_fifo_tb

/* credit_fifo.f */
ram_pkg.sv
ram_sdp_uram.sv
credit_fifo_wr.sv
credit_fifo_rd.sv
credit_fifo.sv
credit_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the credit FIFO testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=credit_fifo_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module credit_fifo_tb \
    -f credit_fifo.f \
    -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
